// ==== common/tmr_params.svh ====
// TMR control unit parameters
// Vote and counter widths, APB address width and register map offsets

`ifndef TMR_PARAMS_SVH
`define TMR_PARAMS_SVH

// Width of one core's compared output word
`define TMR_VOTE_W 32

// APB address width and mismatch counter width
`define TMR_ADDR_W 8
`define TMR_CNT_W  16

// Register offsets
`define TMR_REG_CTRL   8'h00
`define TMR_REG_STATUS 8'h04
`define TMR_REG_CNT0   8'h08
`define TMR_REG_CNT1   8'h0C
`define TMR_REG_CNT2   8'h10

`endif

// ==== common/tmr_pkg.sv ====
// TMR control unit types
// Word, mask and counter types, redundancy mode and the voter/config structs

`default_nettype none

package tmr_pkg;

  `include "tmr_params.svh"

  typedef logic [`TMR_VOTE_W-1:0] vote_t;
  typedef logic [2:0]             core_mask_t;
  typedef logic [`TMR_CNT_W-1:0]  mm_cnt_t;

  typedef enum logic [2:0] {
    NON_TMR,
    TMR_RUN,
    TMR_UNLOAD,
    TMR_RELOAD,
    TMR_RAPID
  } tmr_mode_e;

  // Result of one voting cycle
  typedef struct packed {
    vote_t      voted;
    core_mask_t err;
    logic       single_mm;
    logic       failure;
    logic       valid;
  } vote_res_t;

  // Configuration from the register block
  typedef struct packed {
    logic enable;
    logic setback_en;
    logic reload_setback;
    logic rapid_en;
    logic force_resynch;
  } tmr_cfg_t;

endpackage

`default_nettype wire

// ==== design/tmr_voter.sv ====
// TMR voter
// Registered bitwise 2-of-3 majority over the three core words, with the
// disagreement classified as one dissenting core, total failure or agreement

`timescale 1ns/1ps
`default_nettype none

module tmr_voter import tmr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      core_valid_i,
  input  vote_t     core0_i,
  input  vote_t     core1_i,
  input  vote_t     core2_i,
  output vote_res_t res_o,
  output vote_t     voted_o
);

  logic       eq01, eq02, eq12;
  logic       fail_d;
  vote_t      majority;
  core_mask_t err_d;
  vote_t      voted_q;
  core_mask_t err_q;
  logic       single_q, fail_q, valid_q;

  assign eq01 = (core0_i == core1_i);
  assign eq02 = (core0_i == core2_i);
  assign eq12 = (core1_i == core2_i);

  assign majority = (core0_i & core1_i) | (core0_i & core2_i) | (core1_i & core2_i);

  // A core dissents when the other two agree and differ from it
  assign err_d[0] = eq12 & ~eq01;
  assign err_d[1] = eq02 & ~eq01;
  assign err_d[2] = eq01 & ~eq02;
  assign fail_d   = ~eq01 & ~eq02 & ~eq12;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      err_q    <= '0;
      single_q <= 1'b0;
      fail_q   <= 1'b0;
    end else begin
      valid_q  <= core_valid_i;
      err_q    <= core_valid_i ? err_d : '0;
      single_q <= core_valid_i & (|err_d);
      fail_q   <= core_valid_i & fail_d;
    end
  end

  // No majority exists on failure, core 0 is passed on
  always_ff @(posedge clk_i) begin
    if (core_valid_i) begin
      voted_q <= fail_d ? core0_i : majority;
    end
  end

  assign res_o = '{voted: voted_q, err: err_q, single_mm: single_q,
                   failure: fail_q, valid: valid_q};
  assign voted_o = voted_q;

endmodule

`default_nettype wire

// ==== tmr_ctrl/tmr_ctrl.sv ====
// TMR redundancy mode controller
// Runs the mode FSM (non-redundant, run, unload, reload, rapid recovery)
// and drives setback, resynch and recovery requests and the bus hold

`timescale 1ns/1ps
`default_nettype none

module tmr_ctrl import tmr_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  vote_res_t  res_i,
  input  tmr_cfg_t   cfg_i,
  input  logic       fetch_en_i,
  input  logic       cores_synch_i,
  input  logic       unload_done_i,
  input  logic       reload_done_i,
  input  logic       recovery_done_i,
  input  logic       bus_resp_ok_i,
  output tmr_mode_e  mode_o,
  output core_mask_t incr_o,
  output logic       force_ack_o,
  output core_mask_t setback_o,
  output logic       resynch_req_o,
  output logic       recovery_req_o,
  output logic       bus_hold_o
);

  tmr_mode_e  mode_d, mode_q;
  core_mask_t setback_d, setback_q;
  logic       resynch_q;
  logic       cores_synch_q;
  logic       mismatch;

  assign mismatch = res_i.valid & res_i.single_mm;

  always_comb begin
    mode_d      = mode_q;
    setback_d   = '0;
    force_ack_o = 1'b0;

    case (mode_q)
      TMR_RUN: begin
        if (cfg_i.force_resynch || mismatch) begin
          force_ack_o = cfg_i.force_resynch;
          mode_d      = cfg_i.rapid_en ? TMR_RAPID : TMR_UNLOAD;
        end
      end
      TMR_UNLOAD: begin
        if (unload_done_i) begin
          mode_d = TMR_RELOAD;
          if (cfg_i.setback_en) setback_d = 3'b111;
        end
      end
      TMR_RELOAD: begin
        if (reload_done_i) begin
          mode_d = TMR_RUN;
        end else if ((mismatch || res_i.failure) && cfg_i.setback_en &&
                     cfg_i.reload_setback) begin
          // Error while reloading, restart all cores again
          setback_d = 3'b111;
        end
      end
      TMR_RAPID: begin
        if (recovery_done_i) mode_d = TMR_RUN;
      end
      NON_TMR: begin
        if (cfg_i.enable && cores_synch_q) begin
          if (cfg_i.rapid_en) begin
            mode_d = TMR_RAPID;
          end else begin
            mode_d = TMR_RELOAD;
            if (cfg_i.setback_en) setback_d = 3'b111;
          end
        end
      end
      default: mode_d = NON_TMR;
    endcase

    // Before the cores fetch, the mode simply follows enable
    if (!fetch_en_i) begin
      mode_d      = cfg_i.enable ? TMR_RUN : NON_TMR;
      setback_d   = '0;
      force_ack_o = 1'b0;
    end

    // Split out of lockstep once the outstanding bus traffic has settled
    if (mode_q == TMR_RUN && !cfg_i.enable && bus_resp_ok_i) begin
      mode_d = NON_TMR;
      if (cfg_i.setback_en) setback_d = 3'b110;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q        <= NON_TMR;
      setback_q     <= '0;
      resynch_q     <= 1'b0;
      cores_synch_q <= 1'b0;
    end else begin
      mode_q        <= mode_d;
      setback_q     <= setback_d;
      resynch_q     <= (mode_d == TMR_UNLOAD) && (mode_q != TMR_UNLOAD);
      cores_synch_q <= cores_synch_i;
    end
  end

  // Only mismatches seen in run mode are counted
  assign incr_o = (mode_q == TMR_RUN && mismatch) ? res_i.err : '0;

  assign mode_o         = mode_q;
  assign setback_o      = setback_q;
  assign resynch_req_o  = resynch_q;
  assign recovery_req_o = (mode_q == TMR_RAPID);
  assign bus_hold_o     = (mode_q == TMR_RUN) && !cfg_i.enable;

endmodule

`default_nettype wire

// ==== tmr_regs/tmr_regs.sv ====
// TMR register block
// APB slave without wait states holding the configuration, the mode
// read-back and one saturating mismatch counter per core

`timescale 1ns/1ps
`default_nettype none

`include "tmr_params.svh"

module tmr_regs import tmr_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`TMR_ADDR_W-1:0] paddr_i,
  input  logic [31:0]            pwdata_i,
  output logic [31:0]            prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  input  tmr_mode_e              mode_i,
  input  core_mask_t             incr_i,
  input  logic                   force_ack_i,
  output tmr_cfg_t               cfg_o
);

  tmr_cfg_t   cfg_q;
  mm_cnt_t    cnt_q [3];
  logic       access;
  logic       wr_en;
  logic       hit_ctrl;
  logic       addr_hit;
  core_mask_t hit_cnt;

  assign access = psel_i & penable_i;
  assign wr_en  = access & pwrite_i;

  assign hit_ctrl   = (paddr_i == `TMR_REG_CTRL);
  assign hit_cnt[0] = (paddr_i == `TMR_REG_CNT0);
  assign hit_cnt[1] = (paddr_i == `TMR_REG_CNT1);
  assign hit_cnt[2] = (paddr_i == `TMR_REG_CNT2);
  assign addr_hit   = hit_ctrl | (|hit_cnt) | (paddr_i == `TMR_REG_STATUS);

  // Configuration, force_resynch self-clears once control has taken it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
    end else if (wr_en && hit_ctrl) begin
      cfg_q.enable         <= pwdata_i[0];
      cfg_q.setback_en     <= pwdata_i[1];
      cfg_q.reload_setback <= pwdata_i[2];
      cfg_q.rapid_en       <= pwdata_i[3];
      cfg_q.force_resynch  <= pwdata_i[4];
    end else if (force_ack_i) begin
      cfg_q.force_resynch <= 1'b0;
    end
  end

  // Mismatch counters, any write clears
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int k = 0; k < 3; k++) cnt_q[k] <= '0;
    end else begin
      for (int k = 0; k < 3; k++) begin
        if (wr_en && hit_cnt[k]) begin
          cnt_q[k] <= '0;
        end else if (incr_i[k] && cnt_q[k] != '1) begin
          cnt_q[k] <= cnt_q[k] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    prdata_o = '0;
    case (paddr_i)
      `TMR_REG_CTRL: begin
        prdata_o[4:0] = {cfg_q.force_resynch, cfg_q.rapid_en, cfg_q.reload_setback,
                         cfg_q.setback_en, cfg_q.enable};
      end
      `TMR_REG_STATUS: prdata_o[2:0] = mode_i;
      `TMR_REG_CNT0:   prdata_o[`TMR_CNT_W-1:0] = cnt_q[0];
      `TMR_REG_CNT1:   prdata_o[`TMR_CNT_W-1:0] = cnt_q[1];
      `TMR_REG_CNT2:   prdata_o[`TMR_CNT_W-1:0] = cnt_q[2];
      default:         prdata_o = '0;
    endcase
  end

  assign pready_o  = access;
  assign pslverr_o = access & ~addr_hit;
  assign cfg_o     = cfg_q;

endmodule

`default_nettype wire

// ==== design/tmr_unit_top.sv ====
// TMR control unit top level
// Chains the voter, the mode controller and the APB register block

`timescale 1ns/1ps
`default_nettype none

`include "tmr_params.svh"

module tmr_unit_top import tmr_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // APB
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`TMR_ADDR_W-1:0] paddr_i,
  input  logic [31:0]            pwdata_i,
  output logic [31:0]            prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  // Core outputs to compare
  input  logic                   core_valid_i,
  input  vote_t                  core0_i,
  input  vote_t                  core1_i,
  input  vote_t                  core2_i,
  output vote_t                  voted_o,
  // Control handshakes
  input  logic                   fetch_en_i,
  input  logic                   cores_synch_i,
  input  logic                   unload_done_i,
  input  logic                   reload_done_i,
  input  logic                   recovery_done_i,
  input  logic                   bus_resp_ok_i,
  output tmr_mode_e              mode_o,
  output core_mask_t             setback_o,
  output logic                   resynch_req_o,
  output logic                   recovery_req_o,
  output logic                   bus_hold_o
);

  vote_res_t  vote_res;
  tmr_cfg_t   cfg;
  core_mask_t incr;
  logic       force_ack;

  tmr_voter u_voter (
    .clk_i,
    .rst_ni,
    .core_valid_i,
    .core0_i,
    .core1_i,
    .core2_i,
    .res_o   (vote_res),
    .voted_o
  );

  tmr_ctrl u_ctrl (
    .clk_i,
    .rst_ni,
    .res_i          (vote_res),
    .cfg_i          (cfg),
    .fetch_en_i,
    .cores_synch_i,
    .unload_done_i,
    .reload_done_i,
    .recovery_done_i,
    .bus_resp_ok_i,
    .mode_o,
    .incr_o         (incr),
    .force_ack_o    (force_ack),
    .setback_o,
    .resynch_req_o,
    .recovery_req_o,
    .bus_hold_o
  );

  tmr_regs u_regs (
    .clk_i,
    .rst_ni,
    .psel_i,
    .penable_i,
    .pwrite_i,
    .paddr_i,
    .pwdata_i,
    .prdata_o,
    .pready_o,
    .pslverr_o,
    .mode_i      (mode_o),
    .incr_i      (incr),
    .force_ack_i (force_ack),
    .cfg_o       (cfg)
  );

endmodule

`default_nettype wire

// ==== dv/tmr_unit_checker.sv ====
// TMR control unit assertions
// Bound to the mode controller to watch the request pulses and state outputs

`timescale 1ns/1ps
`default_nettype none

module tmr_unit_checker import tmr_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input tmr_mode_e  mode_i,
  input core_mask_t setback_i,
  input logic       resynch_req_i,
  input logic       recovery_req_i,
  input logic       bus_hold_i,
  input logic       bus_resp_ok_i
);

  int unsigned fail_cnt = 0;

  // Resynch request is a single-cycle pulse
  resynch_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resynch_req_i |=> !resynch_req_i)
    else begin
      $error("resynch_req_o stayed high for more than one cycle");
      fail_cnt++;
    end

  // Bus hold ends in NON_TMR once the outstanding responses are in
  bus_hold_exit_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bus_hold_i && bus_resp_ok_i) |=> (mode_i == NON_TMR))
    else begin
      $error("bus_hold_o released by bus_resp_ok_i without entering NON_TMR");
      fail_cnt++;
    end

  // The setback that comes with the split into NON_TMR is allowed for one cycle
  setback_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode_i == NON_TMR && $past(mode_i) == NON_TMR) |-> (setback_i == 3'b000))
    else begin
      $error("setback_o active while in NON_TMR");
      fail_cnt++;
    end

  reset_quiet_a: assert property (@(posedge clk_i)
    !rst_ni |-> (setback_i == 3'b000 && !resynch_req_i && !recovery_req_i && !bus_hold_i))
    else begin
      $error("Control outputs active during reset");
      fail_cnt++;
    end

endmodule

bind tmr_ctrl tmr_unit_checker u_checker (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .mode_i         (mode_o),
  .setback_i      (setback_o),
  .resynch_req_i  (resynch_req_o),
  .recovery_req_i (recovery_req_o),
  .bus_hold_i     (bus_hold_o),
  .bus_resp_ok_i  (bus_resp_ok_i)
);

`default_nettype wire

// ==== dv/tmr_unit_tb.sv ====
// Testbench for the TMR control unit
// Models three lockstep cores, programs the APB registers and answers the
// control handshakes while checking voting, counters and mode sequencing

`timescale 1ns/1ps
`default_nettype none

`include "tmr_params.svh"

module tmr_unit_tb import tmr_pkg::*; ();

  localparam int WaitMax = 64;

  typedef struct packed {
    vote_t      voted;
    core_mask_t err;
    tmr_mode_e  next_mode;
  } vote_exp_t;

  logic clk_i, rst_ni, psel_i, penable_i, pwrite_i, pready_o, pslverr_o;
  logic [`TMR_ADDR_W-1:0] paddr_i;
  logic [31:0] pwdata_i, prdata_o;
  logic core_valid_i, fetch_en_i, cores_synch_i;
  logic unload_done_i, reload_done_i, recovery_done_i, bus_resp_ok_i;
  logic resynch_req_o, recovery_req_o, bus_hold_o;
  vote_t      core0_i, core1_i, core2_i, voted_o;
  tmr_mode_e  mode_o;
  core_mask_t setback_o;

  logic [31:0] rng;
  logic [4:0]  ctrl_shadow;
  mm_cnt_t     cnt_exp [3];
  logic        vote_pend;
  vote_exp_t   vote_ref;

  tmr_unit_top u_tmr_unit_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Word-level majority, dissenting core and the mode that should follow
  function automatic vote_exp_t ref_vote(input vote_t c0, input vote_t c1, input vote_t c2,
                                         input tmr_mode_e cur, input logic [4:0] ctrl,
                                         input logic fetch);
    vote_exp_t e;
    e.voted     = (c1 == c2) ? c1 : c0;
    e.err       = 3'b000;
    e.next_mode = cur;
    if (c1 == c2 && c0 != c1) e.err = 3'b001;
    else if (c0 == c2 && c1 != c0) e.err = 3'b010;
    else if (c0 == c1 && c2 != c0) e.err = 3'b100;
    if (!fetch) e.next_mode = ctrl[0] ? TMR_RUN : NON_TMR;
    else if (cur == TMR_RUN && e.err != 3'b000) e.next_mode = ctrl[3] ? TMR_RAPID : TMR_UNLOAD;
    return e;
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_vote(input string name, input vote_t got, input vote_t exp);
    if (got !== exp) fail_now($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_mode(input string name, input tmr_mode_e got, input tmr_mode_e exp);
    if (got !== exp) fail_now($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_mask(input string name, input core_mask_t got, input core_mask_t exp);
    if (got !== exp) fail_now($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_cnt(input string name, input mm_cnt_t got, input mm_cnt_t exp);
    if (got !== exp) fail_now($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) fail_now($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // One APB transfer, setup phase then access phase
  task automatic apb_access(input logic wr, input logic [`TMR_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int n;
    next_cycle();
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    next_cycle();
    penable_i = 1'b1;
    n = 0;
    @(negedge clk_i);
    while (!pready_o && n < WaitMax) begin
      @(negedge clk_i);
      n++;
    end
    if (!pready_o) fail_now("APB transfer timed out waiting for pready");
    rdata = prdata_o;
    err   = pslverr_o;
    next_cycle();
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_write(input logic [`TMR_ADDR_W-1:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    logic        err;
    apb_access(1'b1, addr, data, unused, err);
    if (err) fail_now($sformatf("APB write to offset 0x%h raised pslverr", addr));
  endtask

  task automatic apb_read(input logic [`TMR_ADDR_W-1:0] addr, output logic [31:0] data);
    logic err;
    apb_access(1'b0, addr, 32'h0, data, err);
    if (err) fail_now($sformatf("APB read from offset 0x%h raised pslverr", addr));
  endtask

  task automatic write_ctrl(input logic [31:0] data);
    apb_write(`TMR_REG_CTRL, data);
    ctrl_shadow = data[4:0];
  endtask

  task automatic check_counters();
    logic [31:0] rd;
    logic [`TMR_ADDR_W-1:0] addr;
    for (int k = 0; k < 3; k++) begin
      addr = `TMR_REG_CNT0 + `TMR_ADDR_W'(4 * k);
      apb_read(addr, rd);
      check_cnt($sformatf("CNT%0d", k), mm_cnt_t'(rd), cnt_exp[k]);
    end
  endtask

  // Core model, one valid cycle with the chosen core's word corrupted
  task automatic drive_cores(input int bad, input tmr_mode_e cur, output vote_exp_t e);
    vote_t w;
    vote_t flip;
    rng  = next_rand(rng);
    w    = rng;
    rng  = next_rand(rng);
    flip = rng | 32'h1;
    next_cycle();
    core0_i = (bad == 0) ? w ^ flip : w;
    core1_i = (bad == 1) ? w ^ flip : w;
    core2_i = (bad == 2) ? w ^ flip : w;
    core_valid_i = 1'b1;
    e = ref_vote(core0_i, core1_i, core2_i, cur, ctrl_shadow, fetch_en_i);
    if (cur == TMR_RUN) begin
      for (int k = 0; k < 3; k++) if (e.err[k]) cnt_exp[k]++;
    end
    next_cycle();
    core_valid_i = 1'b0;
  endtask

  task automatic drive_done(input int sel, input logic val);
    case (sel)
      0:       unload_done_i   = val;
      1:       reload_done_i   = val;
      2:       recovery_done_i = val;
      default: bus_resp_ok_i   = val;
    endcase
  endtask

  task automatic pulse_input(input int sel);
    next_cycle();
    drive_done(sel, 1'b1);
    next_cycle();
    drive_done(sel, 1'b0);
  endtask

  task automatic wait_mode(input tmr_mode_e m);
    int n;
    n = 0;
    @(negedge clk_i);
    while (mode_o != m && n < WaitMax) begin
      @(negedge clk_i);
      n++;
    end
    if (mode_o != m) fail_now($sformatf("Timed out waiting for mode %s", m.name()));
  endtask

  // Waits for resynch_req_o (0) or bus_hold_o (1)
  task automatic wait_high(input int sel, input string name);
    int n;
    n = 0;
    @(negedge clk_i);
    while (((sel == 0) ? resynch_req_o : bus_hold_o) !== 1'b1 && n < WaitMax) begin
      @(negedge clk_i);
      n++;
    end
    if (((sel == 0) ? resynch_req_o : bus_hold_o) !== 1'b1)
      fail_now($sformatf("Timed out waiting for %s to rise", name));
  endtask

  // Compare process for the voted word, one cycle after each valid sample
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vote_pend <= 1'b0;
    end else begin
      vote_pend <= core_valid_i;
      if (core_valid_i)
        vote_ref <= ref_vote(core0_i, core1_i, core2_i, mode_o, ctrl_shadow, fetch_en_i);
    end
  end

  always @(negedge clk_i) begin
    if (vote_pend) check_vote("voted_o", voted_o, vote_ref.voted);
  end

  initial begin
    logic [31:0] rd;
    logic        err;
    vote_exp_t   e;
    {psel_i, penable_i, pwrite_i, core_valid_i, fetch_en_i, cores_synch_i} = '0;
    {unload_done_i, reload_done_i, recovery_done_i, bus_resp_ok_i} = '0;
    paddr_i = '0;
    pwdata_i = '0;
    core0_i = '0;
    core1_i = '0;
    core2_i = '0;
    rng = 32'h769234d5;
    ctrl_shadow = '0;
    for (int k = 0; k < 3; k++) cnt_exp[k] = '0;
    rst_ni = 1'b0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Register access
    @(negedge clk_i);
    check_mode("mode_o", mode_o, NON_TMR);
    check_mask("setback_o", setback_o, 3'b000);
    apb_read(`TMR_REG_STATUS, rd);
    check_mode("STATUS", tmr_mode_e'(rd[2:0]), NON_TMR);
    write_ctrl(32'h0E);
    apb_read(`TMR_REG_CTRL, rd);
    check_reg("CTRL", rd, 32'h0E);
    apb_access(1'b0, 8'h20, 32'h0, rd, err);
    if (!err) fail_now("Read of unmapped offset 0x20 did not raise pslverr");
    write_ctrl(32'h00);

    // Voting and mismatch counters, fetch still off so the mode stays in run
    write_ctrl(32'h01);
    wait_mode(TMR_RUN);
    for (int i = 0; i < 6; i++) begin
      rng = next_rand(rng);
      drive_cores(int'(rng % 3), TMR_RUN, e);
      check_counters();
      check_mode("mode_o", mode_o, e.next_mode);
    end
    for (int k = 0; k < 3; k++) begin
      apb_write(`TMR_REG_CNT0 + `TMR_ADDR_W'(4 * k), 32'hFFFF_FFFF);
      cnt_exp[k] = '0;
    end
    check_counters();

    // Resynch through unload and reload
    write_ctrl(32'h03);
    next_cycle();
    fetch_en_i = 1'b1;
    drive_cores(1, TMR_RUN, e);
    wait_high(0, "resynch_req_o");
    check_mode("mode_o", mode_o, e.next_mode);
    pulse_input(0);
    @(negedge clk_i);
    check_mode("mode_o", mode_o, TMR_RELOAD);
    check_mask("setback_o", setback_o, 3'b111);
    pulse_input(1);
    @(negedge clk_i);
    check_mode("mode_o", mode_o, TMR_RUN);
    check_mask("setback_o", setback_o, 3'b000);
    check_counters();

    // Rapid recovery on a forced resynch
    write_ctrl(32'h1B);
    wait_mode(TMR_RAPID);
    repeat (3) begin
      @(negedge clk_i);
      check_bit("recovery_req_o", recovery_req_o, 1'b1);
    end
    apb_read(`TMR_REG_CTRL, rd);
    check_reg("CTRL", rd, 32'h0B);
    pulse_input(2);
    @(negedge clk_i);
    check_mode("mode_o", mode_o, TMR_RUN);
    check_bit("recovery_req_o", recovery_req_o, 1'b0);

    // Split out of lockstep
    write_ctrl(32'h02);
    wait_high(1, "bus_hold_o");
    repeat (3) begin
      @(negedge clk_i);
      check_bit("bus_hold_o", bus_hold_o, 1'b1);
      check_mode("mode_o", mode_o, TMR_RUN);
    end
    pulse_input(3);
    @(negedge clk_i);
    check_mode("mode_o", mode_o, NON_TMR);
    check_mask("setback_o", setback_o, 3'b110);
    check_bit("bus_hold_o", bus_hold_o, 1'b0);

    // Back into lockstep once the cores report synch
    next_cycle();
    cores_synch_i = 1'b1;
    write_ctrl(32'h03);
    wait_mode(TMR_RELOAD);
    check_mask("setback_o", setback_o, 3'b111);
    pulse_input(1);
    @(negedge clk_i);
    check_mode("mode_o", mode_o, TMR_RUN);
    next_cycle();
    cores_synch_i = 1'b0;
    repeat (4) next_cycle();

    if (u_tmr_unit_top.u_ctrl.u_checker.fail_cnt != 0) begin
      fail_now("One or more bound assertions failed during the run");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tmr_unit_top.f ====
+incdir+common
common/tmr_pkg.sv
design/tmr_voter.sv
tmr_ctrl/tmr_ctrl.sv
tmr_regs/tmr_regs.sv
design/tmr_unit_top.sv
dv/tmr_unit_checker.sv
dv/tmr_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f tmr_unit_top.f \
  --top-module tmr_unit_tb -o tmr_unit_sim &&
./obj_dir/tmr_unit_sim +verilator+error+limit+100 | tee /dev/stderr |
  grep -q "^Verification passed$" &&
echo "Simulation PASSED" ||
{ echo "Simulation FAILED"; exit 1; }
